// File: include/fpu_defines.svh
/* Widths, pipeline depth and canonical NaN for the FP32 noncomp wrapper */

`ifndef FPU_DEFINES_SVH
`define FPU_DEFINES_SVH

`define FPU_FLEN           32             // Operand and result width
`define FPU_TAG_BITS       3              // Transaction id width
`define FPU_STATUS_BITS    5              // NV DZ OF UF NX, NV on top
`define FPU_NONCOMP_STAGES 2              // Result pipeline depth

// Canonical quiet NaN: positive, all-ones exponent, mantissa MSB only
`define FPU_CANON_NAN      32'h7fc0_0000

`endif

// File: src/fpu_pkg.sv
/* Width typedefs, operator encodings and issue state for the noncomp wrapper */

`default_nettype none

package fpu_pkg;

    `include "fpu_defines.svh"

    // ------------------------------------------------------------------------
    // Data widths
    // ------------------------------------------------------------------------
    typedef logic [`FPU_FLEN-1:0]        fp_word_t;     // One FP32 value
    typedef logic [`FPU_TAG_BITS-1:0]    fpu_tag_t;     // Transaction id
    typedef logic [`FPU_STATUS_BITS-1:0] fpu_status_t;  // NV DZ OF UF NX
    typedef logic [2:0]                  fp_rm_t;       // Raw rm field

    // ------------------------------------------------------------------------
    // Operators
    // ------------------------------------------------------------------------
    // Operator as it arrives from issue
    typedef enum logic [2:0] {
        FSGNJ    = 3'd0,
        FMIN_MAX = 3'd1,
        FCMP     = 3'd2,
        FCLASS   = 3'd3,
        FMV_F2X  = 3'd4,
        FMV_X2F  = 3'd5
    } fu_op_e;

    // Operation seen by the noncomp unit, variant in the sub-op field
    typedef enum logic [1:0] {
        OP_SGNJ     = 2'd0,
        OP_MINMAX   = 2'd1,
        OP_CMP      = 2'd2,
        OP_CLASSIFY = 2'd3
    } noncomp_op_e;

    // Protocol inversion machine
    typedef enum logic {
        READY = 1'b0,  // Upstream sees ready
        STALL = 1'b1   // Hold buffer owns the pipe input
    } issue_state_e;

endpackage

`default_nettype wire

// File: src/fp_op_decode.sv
/* Issue operator and rm field to internal operation and sub-operation */

`timescale 1ns/1ps
`default_nettype none

module fp_op_decode import fpu_pkg::*; (
    input  fu_op_e      fpu_op_i,
    input  fp_rm_t      fpu_rm_i,
    output noncomp_op_e dec_op_o,
    output fp_rm_t      dec_sub_o
);

    fp_rm_t rm_masked;

    // Top rm bit is an alternate-format flag upstream, not a sub-op bit
    assign rm_masked = {1'b0, fpu_rm_i[1:0]};

    always_comb begin : p_decode
        dec_op_o  = OP_SGNJ;    // Sign injection by default
        dec_sub_o = rm_masked;
        unique case (fpu_op_i)
            FSGNJ:    dec_op_o = OP_SGNJ;      // sgnj/sgnjn/sgnjx in rm
            FMIN_MAX: dec_op_o = OP_MINMAX;    // rm[0] picks max
            FCMP:     dec_op_o = OP_CMP;       // le/lt/eq in rm
            FCLASS:   dec_op_o = OP_CLASSIFY;  // rm ignored by the unit
            // Moves need no recoding, run them as raw passthrough
            FMV_F2X,
            FMV_X2F: begin
                dec_op_o  = OP_SGNJ;
                dec_sub_o = 3'b011;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: src/fpu_issue_ctrl.sv
/* READY/STALL machine that inverts the issue handshake, with flush */

`timescale 1ns/1ps
`default_nettype none

module fpu_issue_ctrl import fpu_pkg::*; (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic flush_i,
    input  logic fpu_valid_i,
    input  logic pipe_ready_i,
    output logic fpu_ready_o,
    output logic pipe_valid_o,
    output logic hold_o,      // Capture decoded inputs this cycle
    output logic use_hold_o   // Pipe input comes from the hold buffer
);

    issue_state_e state_q, state_d;

    always_comb begin : p_fsm
        fpu_ready_o  = 1'b0;
        pipe_valid_o = 1'b0;
        hold_o       = 1'b0;
        use_hold_o   = 1'b0;
        state_d      = state_q;
        unique case (state_q)
            READY: begin
                fpu_ready_o  = 1'b1;         // Promise acceptance
                pipe_valid_o = fpu_valid_i;  // Live inputs straight to the pipe
                // Pipe refuses, park the operation and take the token back
                if (fpu_valid_i && !pipe_ready_i) begin
                    fpu_ready_o = 1'b0;
                    hold_o      = 1'b1;
                    state_d     = STALL;
                end
            end
            STALL: begin
                pipe_valid_o = 1'b1;
                use_hold_o   = 1'b1;
                if (pipe_ready_i) begin  // Held op drains this edge
                    fpu_ready_o = 1'b1;
                    state_d     = READY;
                end
            end
            default: ;
        endcase
        if (flush_i) state_d = READY;  // Flush wins over everything
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
        if (!rst_ni) begin
            state_q <= READY;
        end else begin
            state_q <= state_d;
        end
    end

    // ------------------------------------------------------------------------
    // Assertions
    // ------------------------------------------------------------------------
    a_stall_owns_pipe: assert property (@(posedge clk_i) disable iff (!rst_ni)
        state_q == STALL |-> pipe_valid_o && !hold_o);
    a_no_ready_on_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        hold_o |-> !fpu_ready_o);

endmodule

`default_nettype wire

// File: src/fp_hold_buffer.sv
/* Hold register for decoded op, operands and tag, with the bypass mux */

`timescale 1ns/1ps
`default_nettype none

module fp_hold_buffer import fpu_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        hold_i,
    input  logic        use_hold_i,
    input  noncomp_op_e dec_op_i,
    input  fp_rm_t      dec_sub_i,
    input  fp_word_t    operand_a_i,
    input  fp_word_t    operand_b_i,
    input  fpu_tag_t    tag_i,
    output noncomp_op_e sel_op_o,
    output fp_rm_t      sel_sub_o,
    output fp_word_t    sel_a_o,
    output fp_word_t    sel_b_o,
    output fpu_tag_t    sel_tag_o
);

    noncomp_op_e op_q;
    fp_rm_t      sub_q;
    fp_word_t    a_q, b_q;
    fpu_tag_t    tag_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin : p_hold
        if (!rst_ni) begin
            op_q  <= OP_SGNJ;
            sub_q <= '0;
            a_q   <= '0;
            b_q   <= '0;
            tag_q <= '0;
        end else if (hold_i) begin  // Snapshot while upstream is stalled
            op_q  <= dec_op_i;
            sub_q <= dec_sub_i;
            a_q   <= operand_a_i;
            b_q   <= operand_b_i;
            tag_q <= tag_i;
        end
    end

    // Replay the snapshot in STALL, otherwise bypass
    assign sel_op_o  = use_hold_i ? op_q  : dec_op_i;
    assign sel_sub_o = use_hold_i ? sub_q : dec_sub_i;
    assign sel_a_o   = use_hold_i ? a_q   : operand_a_i;
    assign sel_b_o   = use_hold_i ? b_q   : operand_b_i;
    assign sel_tag_o = use_hold_i ? tag_q : tag_i;

endmodule

`default_nettype wire

// File: src/fp_noncomp_unit.sv
/* Combinational FP32 sign injection, min/max, compare and classify */

`timescale 1ns/1ps
`default_nettype none

`include "fpu_defines.svh"

module fp_noncomp_unit import fpu_pkg::*; (
    input  noncomp_op_e op_i,
    input  fp_rm_t      sub_i,
    input  fp_word_t    operand_a_i,
    input  fp_word_t    operand_b_i,
    output fp_word_t    result_o,
    output fpu_status_t status_o
);

    // One-hot class in RISC-V fclass order, bit 0 is -inf, bit 9 is qNaN
    function automatic logic [9:0] fp_class(input fp_word_t x);
        logic [9:0] mask;
        logic       exp_ones, exp_zero, man_zero;
        exp_ones = &x[30:23];
        exp_zero = ~|x[30:23];
        man_zero = ~|x[22:0];
        mask     = '0;
        if (exp_ones && !man_zero)      mask[x[22] ? 9 : 8] = 1'b1;  // qNaN / sNaN
        else if (exp_ones)              mask[x[31] ? 0 : 7] = 1'b1;  // Infinity
        else if (exp_zero && man_zero)  mask[x[31] ? 3 : 4] = 1'b1;  // Zero
        else if (exp_zero)              mask[x[31] ? 2 : 5] = 1'b1;  // Subnormal
        else                            mask[x[31] ? 1 : 6] = 1'b1;  // Normal
        return mask;
    endfunction

    logic [9:0] a_cls, b_cls;
    logic       a_nan, b_nan, any_snan;
    logic       both_zero;
    logic       a_lt_b;     // Total order, -0 below +0
    logic       cmp_lt, cmp_eq;
    logic       nv;

    assign a_cls     = fp_class(operand_a_i);
    assign b_cls     = fp_class(operand_b_i);
    assign a_nan     = a_cls[9] | a_cls[8];
    assign b_nan     = b_cls[9] | b_cls[8];
    assign any_snan  = a_cls[8] | b_cls[8];
    assign both_zero = (a_cls[3] | a_cls[4]) & (b_cls[3] | b_cls[4]);

    // Sign-magnitude compare, flipped magnitude order for two negatives
    assign a_lt_b = (operand_a_i[31] != operand_b_i[31]) ? operand_a_i[31] :
                    operand_a_i[31] ? (operand_a_i[30:0] > operand_b_i[30:0]) :
                                      (operand_a_i[30:0] < operand_b_i[30:0]);

    // IEEE compare treats both zeros as equal
    assign cmp_eq = (operand_a_i == operand_b_i) | both_zero;
    assign cmp_lt = a_lt_b & ~both_zero;

    always_comb begin : p_result
        result_o = '0;
        nv       = 1'b0;
        unique case (op_i)
            // ----------------------------------------------------------------
            // Sign injection, magnitude always from a
            // ----------------------------------------------------------------
            OP_SGNJ: begin
                unique case (sub_i)
                    3'b000:  result_o = {operand_b_i[31], operand_a_i[30:0]};
                    3'b001:  result_o = {~operand_b_i[31], operand_a_i[30:0]};
                    3'b010:  result_o = {operand_a_i[31] ^ operand_b_i[31],
                                         operand_a_i[30:0]};
                    default: result_o = operand_a_i;  // Move passthrough
                endcase
            end
            OP_MINMAX: begin
                nv = any_snan;
                if (a_nan && b_nan)  result_o = `FPU_CANON_NAN;
                else if (a_nan)      result_o = operand_b_i;  // NaN loses
                else if (b_nan)      result_o = operand_a_i;
                else if (sub_i[0])   result_o = a_lt_b ? operand_b_i : operand_a_i;  // Max
                else                 result_o = a_lt_b ? operand_a_i : operand_b_i;
            end
            OP_CMP: begin
                unique case (sub_i)
                    3'b000: begin  // le, signaling
                        nv          = a_nan | b_nan;
                        result_o[0] = ~(a_nan | b_nan) & (cmp_lt | cmp_eq);
                    end
                    3'b001: begin  // lt, signaling
                        nv          = a_nan | b_nan;
                        result_o[0] = ~(a_nan | b_nan) & cmp_lt;
                    end
                    3'b010: begin  // eq, quiet
                        nv          = any_snan;
                        result_o[0] = ~(a_nan | b_nan) & cmp_eq;
                    end
                    default: ;
                endcase
            end
            OP_CLASSIFY: result_o = fp_word_t'(a_cls);
            default: ;
        endcase
    end

    // Only NV can ever be raised here
    assign status_o = {nv, {(`FPU_STATUS_BITS-1){1'b0}}};

endmodule

`default_nettype wire

// File: src/fp_result_pipe.sv
/* Valid/ready stage chain for result, status and tag, flushable */

`timescale 1ns/1ps
`default_nettype none

`include "fpu_defines.svh"

module fp_result_pipe import fpu_pkg::*; #(
    parameter int unsigned NumStages = `FPU_NONCOMP_STAGES  // 1 to 4
) (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        flush_i,
    input  logic        in_valid_i,
    output logic        in_ready_o,
    input  fp_word_t    result_i,
    input  fpu_status_t status_i,
    input  fpu_tag_t    tag_i,
    output logic        out_valid_o,
    input  logic        out_ready_i,
    output fp_word_t    result_o,
    output fpu_status_t status_o,
    output fpu_tag_t    tag_o
);

    if (NumStages < 1 || NumStages > 4) begin : g_bad_depth
        $error("NumStages must be 1 to 4");
    end

    // Index 0 is the pipe input, index i+1 the output of stage i
    logic [NumStages:0] vld, rdy;
    fp_word_t           res [NumStages+1];
    fpu_status_t        sts [NumStages+1];
    fpu_tag_t           tag [NumStages+1];

    assign vld[0]         = in_valid_i;
    assign res[0]         = result_i;
    assign sts[0]         = status_i;
    assign tag[0]         = tag_i;
    assign rdy[NumStages] = out_ready_i;

    for (genvar i = 0; i < NumStages; i++) begin : g_stage
        logic        valid_q;
        fp_word_t    res_q;
        fpu_status_t sts_q;
        fpu_tag_t    tag_q;

        // Stage moves when empty or when its successor takes the item
        assign rdy[i] = !valid_q || rdy[i+1];

        always_ff @(posedge clk_i or negedge rst_ni) begin : p_valid
            if (!rst_ni) begin
                valid_q <= 1'b0;
            end else if (flush_i) begin
                valid_q <= 1'b0;  // Drop everything in flight
            end else if (rdy[i]) begin
                valid_q <= vld[i];
            end
        end

        always_ff @(posedge clk_i) begin : p_data
            if (rdy[i] && vld[i]) begin
                res_q <= res[i];
                sts_q <= sts[i];
                tag_q <= tag[i];
            end
        end

        assign vld[i+1] = valid_q;
        assign res[i+1] = res_q;
        assign sts[i+1] = sts_q;
        assign tag[i+1] = tag_q;
    end

    assign in_ready_o  = rdy[0];
    assign out_valid_o = vld[NumStages];
    assign result_o    = res[NumStages];
    assign status_o    = sts[NumStages];
    assign tag_o       = tag[NumStages];

    // Downstream sees a frozen item until it takes it
    a_out_stable: assert property (@(posedge clk_i) disable iff (!rst_ni || flush_i)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(result_o) &&
                                        $stable(status_o) && $stable(tag_o));

endmodule

`default_nettype wire

// File: src/fpu_noncomp_top.sv
/* FP32 noncomp issue wrapper: decode, protocol inversion, unit and pipeline */

`timescale 1ns/1ps
`default_nettype none

module fpu_noncomp_top import fpu_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        flush_i,
    // Issue side
    input  logic        fpu_valid_i,
    output logic        fpu_ready_o,
    input  fu_op_e      fpu_op_i,
    input  fp_rm_t      fpu_rm_i,
    input  fp_word_t    operand_a_i,
    input  fp_word_t    operand_b_i,
    input  fpu_tag_t    fpu_trans_id_i,
    // Writeback side
    output logic        fpu_valid_o,
    input  logic        fpu_out_ready_i,
    output fp_word_t    result_o,
    output fpu_status_t fpu_status_o,
    output fpu_tag_t    fpu_trans_id_o
);

    noncomp_op_e dec_op, sel_op;
    fp_rm_t      dec_sub, sel_sub;
    fp_word_t    sel_a, sel_b, unit_result;
    fpu_tag_t    sel_tag;
    fpu_status_t unit_status;
    logic        pipe_valid, pipe_ready;
    logic        hold, use_hold;

    fp_op_decode i_decode (
        .fpu_op_i  (fpu_op_i),
        .fpu_rm_i  (fpu_rm_i),
        .dec_op_o  (dec_op),
        .dec_sub_o (dec_sub)
    );

    fpu_issue_ctrl i_ctrl (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .fpu_valid_i  (fpu_valid_i),
        .pipe_ready_i (pipe_ready),
        .fpu_ready_o  (fpu_ready_o),
        .pipe_valid_o (pipe_valid),
        .hold_o       (hold),
        .use_hold_o   (use_hold)
    );

    fp_hold_buffer i_hold (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .hold_i      (hold),
        .use_hold_i  (use_hold),
        .dec_op_i    (dec_op),
        .dec_sub_i   (dec_sub),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .tag_i       (fpu_trans_id_i),
        .sel_op_o    (sel_op),
        .sel_sub_o   (sel_sub),
        .sel_a_o     (sel_a),
        .sel_b_o     (sel_b),
        .sel_tag_o   (sel_tag)
    );

    fp_noncomp_unit i_unit (
        .op_i        (sel_op),
        .sub_i       (sel_sub),
        .operand_a_i (sel_a),
        .operand_b_i (sel_b),
        .result_o    (unit_result),
        .status_o    (unit_status)
    );

    // Result visible at edge N+NumStages for an op taken at edge N
    fp_result_pipe i_pipe (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .flush_i     (flush_i),
        .in_valid_i  (pipe_valid),
        .in_ready_o  (pipe_ready),
        .result_i    (unit_result),
        .status_i    (unit_status),
        .tag_i       (sel_tag),
        .out_valid_o (fpu_valid_o),
        .out_ready_i (fpu_out_ready_i),
        .result_o    (result_o),
        .status_o    (fpu_status_o),
        .tag_o       (fpu_trans_id_o)
    );

endmodule

`default_nettype wire

// File: bench/tb_fpu_noncomp.sv
/* Directed testbench for the FP32 noncomp wrapper: reference model, scoreboard,
   LFSR operands, sign injection, min/max, compare, classify, back-pressure, flush */

`timescale 1ns/1ps
`default_nettype none

`include "fpu_defines.svh"

module tb_fpu_noncomp import fpu_pkg::*; ();

    localparam int STAGES  = `FPU_NONCOMP_STAGES;
    localparam int TIMEOUT = 40;   // Cycles allowed for any single wait

    logic        clk, rst_n, flush;
    logic        in_valid, in_ready, out_valid, out_ready;
    fu_op_e      op;
    fp_rm_t      rm;
    fp_word_t    opa, opb, res;
    fpu_tag_t    in_tag, out_tag, tag_next;
    fpu_status_t sts;

    // Scoreboard in issue order
    fp_word_t    exp_res_q [$];
    fpu_status_t exp_sts_q [$];
    fpu_tag_t    exp_tag_q [$];
    int          exp_due_q [$];     // Cycle count at which the item leaves
    int          due;
    int          cyc = 0;
    logic        check_latency = 1'b0;
    logic [15:0] lfsr = 16'd72;

    fpu_noncomp_top uut (
        .clk_i (clk), .rst_ni (rst_n), .flush_i (flush),
        .fpu_valid_i (in_valid), .fpu_ready_o (in_ready),
        .fpu_op_i (op), .fpu_rm_i (rm), .operand_a_i (opa), .operand_b_i (opb),
        .fpu_trans_id_i (in_tag),
        .fpu_valid_o (out_valid), .fpu_out_ready_i (out_ready),
        .result_o (res), .fpu_status_o (sts), .fpu_trans_id_o (out_tag)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    always @(posedge clk) cyc <= cyc + 1;

    // ------------------------------------------------------------------------
    // Failure reporting and checks
    // ------------------------------------------------------------------------
    task automatic stop_run();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic abort(input string why);
        $display("%s at %0t ns", why, $time);
        stop_run();
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %0t ns: %s = %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    // ------------------------------------------------------------------------
    // Operand source and reference model
    // ------------------------------------------------------------------------
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11+1
    endfunction

    task automatic rand_word(output logic [31:0] w);
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr = lfsr_next(lfsr);  // One step per bit
            w    = {w[30:0], lfsr[0]};
        end
    endtask

    function automatic logic is_nan(input logic [31:0] x);
        return (x[30:23] == 8'hff) && (x[22:0] != 23'd0);
    endfunction

    function automatic logic is_snan(input logic [31:0] x);
        return is_nan(x) && !x[22];
    endfunction

    // Unsigned key that sorts floats in total order, -0 just below +0
    function automatic logic [31:0] order_key(input logic [31:0] x);
        return x[31] ? ~x : {1'b1, x[30:0]};
    endfunction

    function automatic logic [9:0] class_mask(input logic [31:0] x);
        int unsigned idx;
        if (x[30:23] == 8'hff)
            idx = (x[22:0] == 23'd0) ? (x[31] ? 0 : 7) : (x[22] ? 9 : 8);
        else if (x[30:23] == 8'h00)
            idx = (x[22:0] == 23'd0) ? (x[31] ? 3 : 4) : (x[31] ? 2 : 5);
        else
            idx = x[31] ? 1 : 6;
        return 10'b1 << idx;
    endfunction

    // Returns {NV, result} for an issue-side operator
    function automatic logic [32:0] ref_calc(input fu_op_e f, input logic [2:0] r,
                                             input logic [31:0] a, input logic [31:0] b);
        logic [2:0]  sub;
        logic        any_nan, snan, lt, eq, bz, nv;
        logic [31:0] y;
        sub     = {1'b0, r[1:0]};  // Top rm bit ignored
        any_nan = is_nan(a) || is_nan(b);
        snan    = is_snan(a) || is_snan(b);
        bz      = (a[30:0] == 31'd0) && (b[30:0] == 31'd0);
        lt      = order_key(a) < order_key(b);
        eq      = (a == b) || bz;
        y       = '0;
        nv      = 1'b0;
        case (f)
            FSGNJ: begin
                case (sub)
                    3'b000:  y = {b[31], a[30:0]};
                    3'b001:  y = {~b[31], a[30:0]};
                    3'b010:  y = {a[31] ^ b[31], a[30:0]};
                    default: y = a;
                endcase
            end
            FMV_F2X, FMV_X2F: y = a;  // Bits pass unchanged
            FMIN_MAX: begin
                nv = snan;
                if (is_nan(a) && is_nan(b)) y = `FPU_CANON_NAN;
                else if (is_nan(a))         y = b;
                else if (is_nan(b))         y = a;
                else                        y = (lt ^ sub[0]) ? a : b;
            end
            FCMP: begin
                if (sub == 3'b000 || sub == 3'b001) nv = any_nan;
                if (sub == 3'b010)                  nv = snan;
                if (!any_nan) begin
                    case (sub)
                        3'b000:  y[0] = (lt && !bz) || eq;  // le
                        3'b001:  y[0] = lt && !bz;          // lt
                        3'b010:  y[0] = eq;                 // eq
                        default: y[0] = 1'b0;
                    endcase
                end
            end
            FCLASS:  y = {22'd0, class_mask(a)};
            default: y = '0;
        endcase
        return {nv, y};
    endfunction

    // ------------------------------------------------------------------------
    // Issue side
    // ------------------------------------------------------------------------
    task automatic drive_op(input fu_op_e f, input logic [2:0] r,
                            input logic [31:0] a, input logic [31:0] b);
        @(negedge clk);
        in_valid = 1'b1;
        op       = f;
        rm       = r;
        opa      = a;
        opb      = b;
        in_tag   = tag_next;
    endtask

    // Called on a falling edge with the op driven, returns after its accepting edge
    task automatic wait_accept();
        int          waited;
        logic [32:0] exp_v;
        waited = 0;
        #1;
        while (!in_ready && waited < TIMEOUT) begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (!in_ready) begin
            abort("Timed out waiting for the DUT to accept an operation");
        end else begin
            exp_v = ref_calc(op, rm, opa, opb);
            exp_res_q.push_back(exp_v[31:0]);
            exp_sts_q.push_back({exp_v[32], 4'b0000});  // Only NV can be set
            exp_tag_q.push_back(in_tag);
            exp_due_q.push_back(cyc + STAGES);  // Leaves at edge N+STAGES
            tag_next = tag_next + 3'd1;
            @(posedge clk);
        end
    endtask

    task automatic issue_op(input fu_op_e f, input logic [2:0] r,
                            input logic [31:0] a, input logic [31:0] b);
        drive_op(f, r, a, b);
        wait_accept();
    endtask

    task automatic issue_rand(input fu_op_e f, input logic [2:0] r);
        logic [31:0] a, b;
        rand_word(a);
        rand_word(b);
        issue_op(f, r, a, b);
    endtask

    // Stop issuing and wait until every accepted op has come out
    task automatic drain();
        int waited;
        waited = 0;
        @(negedge clk);
        in_valid = 1'b0;
        while (exp_res_q.size() != 0 && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_res_q.size() != 0) abort("Timed out waiting for results to drain");
    endtask

    // Output monitor, transfer happens at the next rising edge
    always @(negedge clk) begin : p_monitor
        #1;
        if (rst_n && out_valid && out_ready) begin
            if (exp_res_q.size() == 0) begin
                abort("DUT produced a result with no operation outstanding");
            end else begin
                check_val("result_o", res, exp_res_q.pop_front());
                check_val("fpu_status_o", 32'(sts), 32'(exp_sts_q.pop_front()));
                check_val("fpu_trans_id_o", 32'(out_tag), 32'(exp_tag_q.pop_front()));
                due = exp_due_q.pop_front();
                if (check_latency) check_val("fpu_valid_o cycle", 32'(cyc), 32'(due));
            end
        end
    end

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------
    task automatic test_sgnj_moves();
        check_latency = 1'b1;        // Full-rate flow, fixed latency
        issue_rand(FSGNJ, 3'b000);
        issue_rand(FSGNJ, 3'b001);
        issue_rand(FSGNJ, 3'b010);
        issue_rand(FSGNJ, 3'b011);
        issue_rand(FSGNJ, 3'b110);   // Masks to sgnjx
        issue_rand(FMV_F2X, 3'b000);
        issue_rand(FMV_X2F, 3'b111);
        drain();
        check_latency = 1'b0;
    endtask

    task automatic minmax_pair(input logic [31:0] a, input logic [31:0] b);
        issue_op(FMIN_MAX, 3'b000, a, b);  // min
        issue_op(FMIN_MAX, 3'b001, a, b);  // max
    endtask

    task automatic test_min_max();
        logic [31:0] a, b;
        minmax_pair(32'h3f80_0000, 32'hc000_0000);  // 1.0, -2.0
        minmax_pair(32'h0000_0000, 32'h8000_0000);  // +0, -0
        minmax_pair(32'h8000_0000, 32'h0000_0000);
        minmax_pair(32'h7fc0_0000, 32'h3fc0_0000);  // qNaN vs 1.5
        minmax_pair(32'hbf00_0000, 32'hffc0_0000);
        minmax_pair(32'h7fc0_0000, 32'hffc0_1234);  // Both NaN
        minmax_pair(32'h7f80_0001, 32'h4000_0000);  // sNaN
        rand_word(a);
        rand_word(b);
        minmax_pair(a, b);
        drain();
    endtask

    task automatic cmp_set(input logic [31:0] a, input logic [31:0] b);
        for (int r = 0; r < 4; r++) issue_op(FCMP, 3'(r), a, b);  // le lt eq none
    endtask

    task automatic test_compare();
        logic [31:0] a, b;
        cmp_set(32'h4049_0fdb, 32'h4049_0fdb);  // Equal
        cmp_set(32'h0000_0000, 32'h8000_0000);
        cmp_set(32'h3f80_0000, 32'h4000_0000);
        cmp_set(32'h4000_0000, 32'h3f80_0000);
        cmp_set(32'hbf80_0000, 32'hc000_0000);  // Two negatives
        cmp_set(32'h7fc0_0000, 32'h3f80_0000);  // qNaN
        cmp_set(32'h3f80_0000, 32'h7f80_0001);  // sNaN
        for (int i = 0; i < 3; i++) begin
            rand_word(a);
            rand_word(b);
            cmp_set(a, b);
        end
        cmp_set(a, a);
        drain();
    endtask

    task automatic test_classify();
        issue_op(FCLASS, 3'b000, 32'hff80_0000, 32'h0);  // -inf
        issue_op(FCLASS, 3'b000, 32'hbf80_0000, 32'h0);
        issue_op(FCLASS, 3'b000, 32'h8000_0001, 32'h0);  // -subnormal
        issue_op(FCLASS, 3'b000, 32'h8000_0000, 32'h0);
        issue_op(FCLASS, 3'b000, 32'h0000_0000, 32'h0);
        issue_op(FCLASS, 3'b000, 32'h0040_0000, 32'h0);  // +subnormal
        issue_op(FCLASS, 3'b000, 32'h3f80_0000, 32'h0);
        issue_op(FCLASS, 3'b000, 32'h7f80_0000, 32'h0);  // +inf
        issue_op(FCLASS, 3'b000, 32'h7f80_0001, 32'h0);
        issue_op(FCLASS, 3'b000, 32'h7fc0_0000, 32'h0);  // qNaN
        drain();
    endtask

    // Fill pipe while downstream is stuck, then fill hold buffer
    task automatic fill_until_stall(output int accepted);
        logic [31:0] a, b;
        logic        stalled;
        accepted = 0;
        stalled  = 1'b0;
        while (!stalled && accepted < STAGES + 2) begin
            rand_word(a);
            rand_word(b);
            drive_op(FSGNJ, 3'b010, a, b);
            #1;
            if (in_ready) begin
                wait_accept();
                accepted++;
            end else begin
                stalled = 1'b1;  // Op now parked, upstream keeps it driven
            end
        end
    endtask

    task automatic test_back_pressure();
        int accepted;
        @(negedge clk);
        out_ready = 1'b0;
        fill_until_stall(accepted);
        check_val("ops accepted before stall", 32'(accepted), 32'(STAGES));
        repeat (3) begin
            @(negedge clk);
            #1;
            check_val("fpu_ready_o", 32'(in_ready), 32'd0);
            check_val("fpu_valid_o", 32'(out_valid), 32'd1);
        end
        @(negedge clk);
        out_ready = 1'b1;            // Release, the parked op goes in
        wait_accept();
        issue_rand(FMIN_MAX, 3'b001);
        issue_rand(FCMP, 3'b000);
        issue_rand(FCLASS, 3'b000);
        drain();
    endtask

    task automatic test_flush();
        int accepted;
        @(negedge clk);
        out_ready = 1'b0;
        fill_until_stall(accepted);
        @(negedge clk);              // Now in STALL
        #1;
        check_val("fpu_ready_o", 32'(in_ready), 32'd0);
        @(negedge clk);
        flush    = 1'b1;
        in_valid = 1'b0;
        @(negedge clk);
        flush = 1'b0;
        exp_res_q.delete();          // Everything in flight is gone
        exp_sts_q.delete();
        exp_tag_q.delete();
        exp_due_q.delete();
        #1;
        check_val("fpu_valid_o", 32'(out_valid), 32'd0);
        check_val("fpu_ready_o", 32'(in_ready), 32'd1);
        out_ready = 1'b1;
        repeat (4) @(negedge clk);   // Monitor traps any stray result
        issue_rand(FSGNJ, 3'b001);
        drain();
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        rst_n     = 1'b0;
        flush     = 1'b0;
        in_valid  = 1'b0;
        op        = FSGNJ;
        rm        = '0;
        opa       = '0;
        opb       = '0;
        in_tag    = '0;
        tag_next  = '0;
        out_ready = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        check_val("fpu_ready_o", 32'(in_ready), 32'd1);
        check_val("fpu_valid_o", 32'(out_valid), 32'd0);

        test_sgnj_moves();
        test_min_max();
        test_compare();
        test_classify();
        test_back_pressure();
        test_flush();

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: fpu_noncomp_top.f
+incdir+include
src/fpu_pkg.sv
src/fp_op_decode.sv
src/fpu_issue_ctrl.sv
src/fp_hold_buffer.sv
src/fp_noncomp_unit.sv
src/fp_result_pipe.sv
src/fpu_noncomp_top.sv
bench/tb_fpu_noncomp.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the noncomp wrapper testbench with Verilator and run it.
# The exit status is the simulator's, nonzero on any $fatal.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_fpu_noncomp \
    -f fpu_noncomp_top.f \
    -o tb_fpu_noncomp \
    && ./obj_dir/tb_fpu_noncomp \
    || { echo "Simulation run did not complete cleanly"; exit 1; }
